/* compile.f */
logic/uart_pkg.sv
logic/dbg_pkg.sv
logic/fifo_if.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/cmd_framer.sv
logic/sync_fifo.sv
logic/dbg_engine.sv
logic/uart_dbg_top.sv
dv/tb_clock.sv
dv/uart_dbg_sva.sv
dv/uart_dbg_tb.sv

/* dv/tb_clock.sv */
module tb_clock #(
    parameter int period = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

/* dv/uart_dbg_sva.sv */
module uart_dbg_sva (
    input logic clk,
    input logic reset_n,
    input logic mem_cmd_en,
    input logic mem_cmd_rw,
    input logic mem_cmd_full,
    input logic mem_wr_en,
    input logic mem_rd_en,
    input logic mem_rd_empty
);

    int fail_count = 0;  // polled by the testbench

    cmd_en_not_full: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(mem_cmd_en) |-> !mem_cmd_full)
        else begin
            $error("mem_cmd_en rose while mem_cmd_full was high");
            fail_count = fail_count + 1;
        end

    rd_en_not_empty: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(mem_rd_en) |-> !mem_rd_empty)
        else begin
            $error("mem_rd_en rose while mem_rd_empty was high");
            fail_count = fail_count + 1;
        end

    // every strobe is a single cycle
    enables_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        !($past(mem_cmd_en) && mem_cmd_en) && !($past(mem_wr_en) && mem_wr_en)
            && !($past(mem_rd_en) && mem_rd_en))
        else begin
            $error("memory port enable held for more than one cycle");
            fail_count = fail_count + 1;
        end

    wr_with_cmd: assert property (@(posedge clk) disable iff (!reset_n)
        mem_wr_en |-> mem_cmd_en && !mem_cmd_rw)
        else begin
            $error("mem_wr_en without a write command");
            fail_count = fail_count + 1;
        end

endmodule

bind dbg_engine uart_dbg_sva mem_port_sva_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .mem_cmd_en   (mem_cmd_en),
    .mem_cmd_rw   (mem_cmd_rw),
    .mem_cmd_full (mem_cmd_full),
    .mem_wr_en    (mem_wr_en),
    .mem_rd_en    (mem_rd_en),
    .mem_rd_empty (mem_rd_empty)
);

/* dv/uart_dbg_tb.sv */
module uart_dbg_tb;
    import uart_pkg::*;
    import dbg_pkg::*;

    typedef struct packed {
        logic [7:0] op;
        logic [7:0] arg;
        logic       reply;
        logic [7:0] exp;
        logic       hold;   // pin the port levels to lv
        logic [2:0] lv;     // cmd_full, wr_full, rd_empty
    } step_t;

    localparam int drive_delay = 2;
    localparam logic [addr_width-1:0] wr_addr = 30'h1234_5605;
    localparam logic [data_width-1:0] wr_data = 32'h6b1d_e94c;
    localparam logic [7:0] wr_mask_arg = 8'hf0;  // only the low nibble loads
    localparam logic [data_width-1:0] cap_word = 32'h5ee0_d1a9;

    localparam int n_steps = 29;
    localparam step_t steps [n_steps] = '{
        '{op_ping,        8'h00,                  1'b1, ack_byte,         1'b0, 3'b000},
        '{op_addr_b0,     wr_addr[7:0],           1'b0, 8'h00,            1'b0, 3'b000},
        '{op_addr_b1,     wr_addr[15:8],          1'b0, 8'h00,            1'b0, 3'b000},
        '{op_addr_b2,     wr_addr[23:16],         1'b0, 8'h00,            1'b0, 3'b000},
        '{op_addr_b3,     {2'b11, wr_addr[29:24]}, 1'b0, 8'h00,           1'b0, 3'b000},
        '{op_wdat_b0,     wr_data[7:0],           1'b0, 8'h00,            1'b0, 3'b000},
        '{op_wdat_b1,     wr_data[15:8],          1'b0, 8'h00,            1'b0, 3'b000},
        '{op_wdat_b2,     wr_data[23:16],         1'b0, 8'h00,            1'b0, 3'b000},
        '{op_wdat_b3,     wr_data[31:24],         1'b0, 8'h00,            1'b0, 3'b000},
        '{op_mask,        wr_mask_arg,            1'b0, 8'h00,            1'b0, 3'b000},
        '{op_mem_wr,      8'h00,                  1'b1, ack_byte,         1'b0, 3'b000},
        '{op_mem_rd,      8'h00,                  1'b1, ack_byte,         1'b0, 3'b000},
        '{op_rd_b0,       8'h00,                  1'b1, wr_data[7:0],     1'b0, 3'b000},
        '{op_rd_b1,       8'h00,                  1'b1, wr_data[15:8],    1'b0, 3'b000},
        '{op_rd_b2,       8'h00,                  1'b1, wr_data[23:16],   1'b0, 3'b000},
        '{op_rd_b3,       8'h00,                  1'b1, wr_data[31:24],   1'b0, 3'b000},
        '{op_st_cmd_full, 8'h00,                  1'b1, 8'h01,            1'b1, 3'b101},
        '{op_st_wr_full,  8'h00,                  1'b1, 8'h00,            1'b1, 3'b101},
        '{op_st_rd_empty, 8'h00,                  1'b1, 8'h01,            1'b1, 3'b101},
        '{op_st_cmd_full, 8'h00,                  1'b1, 8'h00,            1'b1, 3'b010},
        '{op_st_wr_full,  8'h00,                  1'b1, 8'h01,            1'b1, 3'b010},
        '{op_st_rd_empty, 8'h00,                  1'b1, 8'h00,            1'b1, 3'b010},
        '{op_capture,     8'h00,                  1'b0, 8'h00,            1'b0, 3'b000},
        '{op_rd_b0,       8'h00,                  1'b1, cap_word[7:0],    1'b0, 3'b000},
        '{op_rd_b1,       8'h00,                  1'b1, cap_word[15:8],   1'b0, 3'b000},
        '{op_rd_b2,       8'h00,                  1'b1, cap_word[23:16],  1'b0, 3'b000},
        '{op_rd_b3,       8'h00,                  1'b1, cap_word[31:24],  1'b0, 3'b000},
        '{8'h44,          8'h55,                  1'b0, 8'h00,            1'b0, 3'b000},
        '{op_ping,        8'h00,                  1'b1, ack_byte,         1'b0, 3'b000}
    };

    // two bytes in, one reply out, plus port stalls
    localparam int frame_cycles   = frame_bits * clks_per_bit;
    localparam int cmd_cycles     = 3 * frame_cycles + 64;
    localparam int drain_cycles   = 2 * frame_cycles;
    localparam int timeout_cycles = 32 + (n_steps + 2) * cmd_cycles + drain_cycles;

    logic clk;
    logic reset_n;
    logic serial_rxd;
    logic serial_txd;
    logic [data_width-1:0] debug_in;
    logic mem_cmd_en;
    logic mem_cmd_rw;
    logic [addr_width-1:0] mem_cmd_addr;
    logic mem_cmd_full;
    logic mem_wr_en;
    logic [data_width-1:0] mem_wr_data;
    logic [mask_width-1:0] mem_wr_mask;
    logic mem_wr_full;
    logic mem_rd_en;
    logic [data_width-1:0] mem_rd_data;
    logic mem_rd_empty;

    int seed = 32'hc8a3_93b9;
    int cycle_count = 0;
    int write_count = 0;
    int rx_taken;
    int stretch = 0;
    int rd_wait = 0;
    logic hold_levels;
    logic [2:0] held_lv;
    logic [7:0] rx_shift;
    logic [7:0] rx_bytes [$];
    logic [3:0] rd_pend [$];
    logic [data_width-1:0] mem_words [16];

    tb_clock #(.period(40)) tb_clock_inst (.clk(clk));

    uart_dbg_top uart_dbg_top_inst (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic compare_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) abort_run($sformatf("error %s: got %h expected %h", name, got, exp));
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [frame_bits-1:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < frame_bits; i++) begin
            @(posedge clk);
            #drive_delay serial_rxd = frame[i];
            repeat (clks_per_bit - 1) @(posedge clk);
        end
    endtask

    task automatic apply_step(input step_t s);
        hold_levels = s.hold;
        held_lv     = s.lv;
        send_byte(s.op);
        send_byte(s.arg);
        if (s.reply) begin
            while (rx_bytes.size() <= rx_taken) @(posedge clk);
            compare_val("serial_txd byte", 32'(rx_bytes[rx_taken]), 32'(s.exp));
            rx_taken++;
        end
    endtask

    // serial_txd monitor, samples at bit centres
    initial begin
        forever begin
            @(posedge clk);
            if (reset_n === 1'b1 && serial_txd === 1'b0) begin
                repeat (clks_per_bit / 2) @(posedge clk);
                for (int i = 0; i < byte_width; i++) begin
                    repeat (clks_per_bit) @(posedge clk);
                    rx_shift[i] = serial_txd;
                end
                repeat (clks_per_bit) @(posedge clk);
                if (serial_txd !== 1'b1) abort_run("reply frame on serial_txd has no stop bit");
                rx_bytes.push_back(rx_shift);
            end
        end
    end

    // memory port model
    initial begin
        mem_cmd_full = 1'b0;
        mem_wr_full  = 1'b0;
        mem_rd_empty = 1'b1;
        mem_rd_data  = '0;
        for (int i = 0; i < 16; i++) mem_words[i] = 32'(i + 1) * 32'h9e37_79b9;
        forever begin
            @(posedge clk);
            if (mem_cmd_en) compare_val("mem_cmd_addr", 32'(mem_cmd_addr), 32'(wr_addr));
            if (mem_wr_en) begin
                compare_val("mem_wr_data", mem_wr_data, wr_data);
                compare_val("mem_wr_mask", 32'(mem_wr_mask), 32'(wr_mask_arg[3:0]));
                for (int b = 0; b < mask_width; b++) begin
                    if (!mem_wr_mask[b]) mem_words[mem_cmd_addr[3:0]][8*b +: 8] = mem_wr_data[8*b +: 8];
                end
                write_count++;
            end
            if (mem_cmd_en && mem_cmd_rw) begin
                rd_pend.push_back(mem_cmd_addr[3:0]);
                rd_wait = ($random(seed) & 7) + 1;
            end
            if (mem_rd_en) rd_pend.delete(0);
            if (rd_wait > 0) rd_wait--;
            #drive_delay;
            if (hold_levels) begin
                {mem_cmd_full, mem_wr_full, mem_rd_empty} = held_lv;
            end else begin
                if (stretch == 0) begin
                    stretch      = ($random(seed) & 7) + 1;
                    mem_cmd_full = ($random(seed) & 1) != 0;
                end
                stretch--;
                mem_wr_full  = 1'b0;
                mem_rd_empty = !(rd_pend.size() != 0 && rd_wait == 0);
                if (rd_pend.size() != 0) mem_rd_data = mem_words[rd_pend[0]];
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles)
            abort_run($sformatf("timeout after %0d cycles, command table not finished", cycle_count));
        if (uart_dbg_top_inst.dbg_engine_inst.mem_port_sva_inst.fail_count != 0)
            abort_run("a memory port assertion failed");
    end

    initial begin
        reset_n     = 1'b0;
        serial_rxd  = 1'b1;
        debug_in    = cap_word;
        hold_levels = 1'b0;
        held_lv     = 3'b000;
        rx_taken    = 0;
        repeat (16) @(posedge clk);
        compare_val("serial_txd", 32'(serial_txd), 32'd1);
        compare_val("mem_cmd_en", 32'(mem_cmd_en), 32'd0);
        compare_val("mem_cmd_rw", 32'(mem_cmd_rw), 32'd1);
        compare_val("mem_wr_en", 32'(mem_wr_en), 32'd0);
        compare_val("mem_rd_en", 32'(mem_rd_en), 32'd0);
        #drive_delay reset_n = 1'b1;
        repeat (4) @(posedge clk);
        repeat (3) send_byte(8'h00);  // idle fill ahead of the first opcode
        for (int i = 0; i < n_steps; i++) apply_step(steps[i]);
        repeat (drain_cycles) @(posedge clk);
        compare_val("reply_count", 32'(rx_bytes.size()), 32'(rx_taken));
        compare_val("write_count", 32'(write_count), 32'd1);
        if (uart_dbg_top_inst.dbg_engine_inst.mem_port_sva_inst.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("a memory port assertion failed");
        end
    end

endmodule

/* logic/cmd_framer.sv */
module cmd_framer (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            byte_valid,
    input  logic [uart_pkg::byte_width-1:0] byte_data,
    fifo_if.writer                          cmd_q
);
    import dbg_pkg::*;

    logic have_op;   // opcode received, waiting for argument
    op_t  pend_op;
    cmd_t next_cmd;

    assign next_cmd = '{opcode: pend_op, arg: byte_data};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            have_op    <= 1'b0;
            cmd_q.push <= 1'b0;
        end else begin
            cmd_q.push <= 1'b0;
            if (byte_valid) begin
                if (!have_op) begin
                    if (byte_data != '0) have_op <= 1'b1;  // 00 is idle fill
                end else begin
                    have_op    <= 1'b0;
                    cmd_q.push <= !cmd_q.full;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid && !have_op) pend_op <= op_t'(byte_data);
        if (byte_valid && have_op) cmd_q.wdata <= next_cmd;
    end

endmodule

/* logic/dbg_engine.sv */
module dbg_engine (
    input  logic                            clk,
    input  logic                            reset_n,
    fifo_if.reader                          cmd_q,
    fifo_if.writer                          rep_q,
    output logic                            mem_cmd_en,
    output logic                            mem_cmd_rw,
    output logic [dbg_pkg::addr_width-1:0]  mem_cmd_addr,
    input  logic                            mem_cmd_full,
    output logic                            mem_wr_en,
    output logic [dbg_pkg::data_width-1:0]  mem_wr_data,
    output logic [dbg_pkg::mask_width-1:0]  mem_wr_mask,
    input  logic                            mem_wr_full,
    output logic                            mem_rd_en,
    input  logic [dbg_pkg::data_width-1:0]  mem_rd_data,
    input  logic                            mem_rd_empty,
    input  logic [dbg_pkg::data_width-1:0]  debug_in
);
    import dbg_pkg::*;

    cmd_t                  cmd;
    logic [addr_width-1:0] addr_reg;
    logic [data_width-1:0] wdat_reg;
    logic [data_width-1:0] rd_reg;
    logic [mask_width-1:0] mask_reg;

    logic       active;     // memory op in flight
    logic       mem_is_wr;
    logic       step;       // 0 command phase, 1 read data phase
    logic       rd_go;
    logic       rd_fetch;
    logic       wr_go;
    logic       reply_en;
    logic [7:0] reply_byte;

    assign cmd = cmd_q.rdata;

    // a reply still on its way into rep_q also blocks the next pop
    assign cmd_q.pop = !active && !cmd_q.empty && !rep_q.full && !rep_q.push;

    assign rd_go    = active && !mem_is_wr && !step && !mem_cmd_full;
    assign rd_fetch = active && !mem_is_wr && step && !mem_rd_empty;
    assign wr_go    = active && mem_is_wr && !step && !mem_cmd_full && !mem_wr_full;

    assign mem_cmd_en   = rd_go || wr_go;
    assign mem_wr_en    = wr_go;
    assign mem_rd_en    = rd_fetch;
    assign mem_cmd_rw   = !(active && mem_is_wr);  // read unless a write is pending
    assign mem_cmd_addr = addr_reg;
    assign mem_wr_data  = wdat_reg;
    assign mem_wr_mask  = mask_reg;

    always_comb begin
        reply_en   = 1'b1;
        reply_byte = ack_byte;
        case (cmd.opcode)
            op_ping:        reply_byte = ack_byte;
            op_rd_b0:       reply_byte = rd_reg[7:0];
            op_rd_b1:       reply_byte = rd_reg[15:8];
            op_rd_b2:       reply_byte = rd_reg[23:16];
            op_rd_b3:       reply_byte = rd_reg[31:24];
            op_st_cmd_full: reply_byte = {7'b0, mem_cmd_full};
            op_st_wr_full:  reply_byte = {7'b0, mem_wr_full};
            op_st_rd_empty: reply_byte = {7'b0, mem_rd_empty};
            default:        reply_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active     <= 1'b0;
            mem_is_wr  <= 1'b0;
            step       <= 1'b0;
            rep_q.push <= 1'b0;
        end else begin
            rep_q.push <= (cmd_q.pop && reply_en) || rd_fetch || wr_go;
            if (cmd_q.pop && (cmd.opcode == op_mem_rd || cmd.opcode == op_mem_wr)) begin
                active    <= 1'b1;
                mem_is_wr <= cmd.opcode == op_mem_wr;
                step      <= 1'b0;
            end
            if (rd_go) step <= 1'b1;
            if (rd_fetch || wr_go) active <= 1'b0;  // ack goes out next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_q.pop) rep_q.wdata <= reply_byte;
        else if (rd_fetch || wr_go) rep_q.wdata <= ack_byte;

        if (rd_fetch) rd_reg <= mem_rd_data;

        if (cmd_q.pop) begin
            case (cmd.opcode)
                op_addr_b0: addr_reg[7:0]   <= cmd.arg;
                op_addr_b1: addr_reg[15:8]  <= cmd.arg;
                op_addr_b2: addr_reg[23:16] <= cmd.arg;
                op_addr_b3: addr_reg[29:24] <= cmd.arg[5:0];
                op_wdat_b0: wdat_reg[7:0]   <= cmd.arg;
                op_wdat_b1: wdat_reg[15:8]  <= cmd.arg;
                op_wdat_b2: wdat_reg[23:16] <= cmd.arg;
                op_wdat_b3: wdat_reg[31:24] <= cmd.arg;
                op_mask:    mask_reg        <= cmd.arg[3:0];  // 1 blocks a byte lane
                op_capture: rd_reg          <= debug_in;
                default:    ;
            endcase
        end
    end

endmodule

/* logic/dbg_pkg.sv */
package dbg_pkg;

    localparam int addr_width = 30;
    localparam int data_width = 32;
    localparam int mask_width = 4;

    localparam int fifo_depth = 4;  // power of two, pointers wrap
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

    localparam logic [7:0] ack_byte = 8'h7b;

    typedef enum logic [7:0] {
        op_ping        = 8'h01,
        op_rd_b0       = 8'h10,
        op_rd_b1       = 8'h11,
        op_rd_b2       = 8'h12,
        op_rd_b3       = 8'h13,
        op_addr_b0     = 8'h20,
        op_addr_b1     = 8'h21,
        op_addr_b2     = 8'h22,
        op_addr_b3     = 8'h23,  // low 6 bits only
        op_wdat_b0     = 8'h24,
        op_wdat_b1     = 8'h25,
        op_wdat_b2     = 8'h26,
        op_wdat_b3     = 8'h27,
        op_mask        = 8'h29,
        op_mem_rd      = 8'h30,
        op_mem_wr      = 8'h31,
        op_st_cmd_full = 8'h32,
        op_st_wr_full  = 8'h33,
        op_st_rd_empty = 8'h35,
        op_capture     = 8'h39
    } op_t;

    typedef struct packed {
        op_t        opcode;
        logic [7:0] arg;
    } cmd_t;

endpackage

/* logic/fifo_if.sv */
interface fifo_if #(
    parameter type payload_t = logic [7:0]
);

    logic     push;
    payload_t wdata;
    logic     full;
    logic     pop;
    payload_t rdata;   // head entry, valid while empty is low
    logic     empty;

    modport writer (output push, output wdata, input full);

    modport reader (output pop, input rdata, input empty);

    modport store (
        input  push,
        input  wdata,
        output full,
        input  pop,
        output rdata,
        output empty
    );

endinterface

/* logic/sync_fifo.sv */
module sync_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  logic  clk,
    input  logic  reset_n,
    fifo_if.store q
);
    import dbg_pkg::*;

    payload_t              mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = q.push && !q.full;   // dropped when full
    assign do_pop  = q.pop && !q.empty;

    assign q.full  = count == fifo_cnt_w'(fifo_depth);
    assign q.empty = count == '0;
    assign q.rdata = mem[rd_ptr];  // fall-through head

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= q.wdata;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* logic/uart_dbg_top.sv */
module uart_dbg_top (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           serial_rxd,
    output logic                           serial_txd,
    input  logic [dbg_pkg::data_width-1:0] debug_in,
    output logic                           mem_cmd_en,
    output logic                           mem_cmd_rw,
    output logic [dbg_pkg::addr_width-1:0] mem_cmd_addr,
    input  logic                           mem_cmd_full,
    output logic                           mem_wr_en,
    output logic [dbg_pkg::data_width-1:0] mem_wr_data,
    output logic [dbg_pkg::mask_width-1:0] mem_wr_mask,
    input  logic                           mem_wr_full,
    output logic                           mem_rd_en,
    input  logic [dbg_pkg::data_width-1:0] mem_rd_data,
    input  logic                           mem_rd_empty
);
    import uart_pkg::*;
    import dbg_pkg::*;

    logic                  rx_valid;
    logic [byte_width-1:0] rx_data;

    fifo_if #(.payload_t(cmd_t)) cmd_q ();
    fifo_if #(.payload_t(logic [byte_width-1:0])) rep_q ();

    uart_rx uart_rx_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .rxd        (serial_rxd),
        .byte_valid (rx_valid),
        .byte_data  (rx_data)
    );

    cmd_framer cmd_framer_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .byte_valid (rx_valid),
        .byte_data  (rx_data),
        .cmd_q      (cmd_q)
    );

    sync_fifo #(.payload_t(cmd_t)) cmd_fifo_inst (.clk(clk), .reset_n(reset_n), .q(cmd_q));

    sync_fifo #(.payload_t(logic [byte_width-1:0])) rep_fifo_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .q       (rep_q)
    );

    dbg_engine dbg_engine_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .cmd_q        (cmd_q),
        .rep_q        (rep_q),
        .mem_cmd_en   (mem_cmd_en),
        .mem_cmd_rw   (mem_cmd_rw),
        .mem_cmd_addr (mem_cmd_addr),
        .mem_cmd_full (mem_cmd_full),
        .mem_wr_en    (mem_wr_en),
        .mem_wr_data  (mem_wr_data),
        .mem_wr_mask  (mem_wr_mask),
        .mem_wr_full  (mem_wr_full),
        .mem_rd_en    (mem_rd_en),
        .mem_rd_data  (mem_rd_data),
        .mem_rd_empty (mem_rd_empty),
        .debug_in     (debug_in)
    );

    uart_tx uart_tx_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .rep_q   (rep_q),
        .txd     (serial_txd)
    );

endmodule

/* logic/uart_pkg.sv */
package uart_pkg;

    localparam int clks_per_bit = 8;            // kept small for simulation
    localparam int byte_width   = 8;
    localparam int frame_bits   = byte_width + 2;  // start, data, stop

    // counter widths
    localparam int baud_cnt_w  = $clog2(clks_per_bit);
    localparam int bit_cnt_w   = $clog2(byte_width);
    localparam int frame_cnt_w = $clog2(frame_bits);

endpackage

/* logic/uart_rx.sv */
module uart_rx (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            rxd,
    output logic                            byte_valid,
    output logic [uart_pkg::byte_width-1:0] byte_data
);
    import uart_pkg::*;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t             state;
    logic [1:0]            rxd_sync;
    logic                  rxd_s;
    logic [baud_cnt_w-1:0] baud_cnt;
    logic [bit_cnt_w-1:0]  bit_idx;
    logic                  half_end;
    logic                  baud_end;

    assign rxd_s    = rxd_sync[1];
    assign half_end = baud_cnt == baud_cnt_w'(clks_per_bit / 2 - 1);
    assign baud_end = baud_cnt == baud_cnt_w'(clks_per_bit - 1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rxd_sync   <= 2'b11;
            state      <= rx_idle;
            baud_cnt   <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            rxd_sync   <= {rxd_sync[0], rxd};
            byte_valid <= 1'b0;
            baud_cnt   <= baud_cnt + 1'b1;
            case (state)
                rx_idle: begin
                    baud_cnt <= '0;
                    if (!rxd_s) state <= rx_start;
                end
                rx_start: if (half_end) begin
                    baud_cnt <= '0;
                    state    <= rxd_s ? rx_idle : rx_data;  // glitch, back to idle
                end
                rx_data: if (baud_end) begin
                    baud_cnt <= '0;
                    bit_idx  <= bit_idx + 1'b1;
                    if (bit_idx == bit_cnt_w'(byte_width - 1)) state <= rx_stop;
                end
                rx_stop: if (baud_end) begin
                    byte_valid <= rxd_s;  // framing error drops the byte
                    state      <= rx_idle;
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (state == rx_data && baud_end) byte_data <= {rxd_s, byte_data[byte_width-1:1]};
    end

endmodule

/* logic/uart_tx.sv */
module uart_tx (
    input  logic   clk,
    input  logic   reset_n,
    fifo_if.reader rep_q,
    output logic   txd
);
    import uart_pkg::*;

    logic                   busy;
    logic [baud_cnt_w-1:0]  baud_cnt;
    logic [frame_cnt_w-1:0] bit_idx;   // bits finished in this frame
    logic [byte_width:0]    shift;     // stop bit above the data
    logic                   baud_end;

    assign baud_end  = baud_cnt == baud_cnt_w'(clks_per_bit - 1);
    assign rep_q.pop = !busy && !rep_q.empty;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy     <= 1'b0;
            txd      <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else if (rep_q.pop) begin
            busy     <= 1'b1;
            txd      <= 1'b0;  // start bit
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else if (busy) begin
            baud_cnt <= baud_cnt + 1'b1;
            if (baud_end) begin
                baud_cnt <= '0;
                bit_idx  <= bit_idx + 1'b1;
                txd      <= shift[0];
                if (bit_idx == frame_cnt_w'(frame_bits - 1)) begin
                    busy <= 1'b0;
                    txd  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rep_q.pop) shift <= {1'b1, rep_q.rdata};
        else if (busy && baud_end) shift <= {1'b1, shift[byte_width:1]};
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the bridge testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --Mdir obj_dir \
    --top-module uart_dbg_tb -f compile.f -o uart_dbg_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/uart_dbg_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -qF -- ">>> FAIL" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
grep -qF -- ">>> PASS" sim.log || exit 1
exit 0
